// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;
    localparam int OpcodeW  = 7;
    localparam int Funct3W  = 3;

    // Instruction field positions
    localparam int RdLsb     = 7;
    localparam int Funct3Lsb = 12;
    localparam int Rs1Lsb    = 15;
    localparam int Rs2Lsb    = 20;
    localparam int Funct7Lsb = 25;
    localparam int AltBit    = 30;    // funct7 bit picking sub over add

    // Major opcodes of the supported subset
    typedef enum logic [OpcodeW-1:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpLui    = 7'b0110111
    } opcodeT;

    // Low three bits follow funct3, top bit follows the alt funct7 bit
    typedef enum logic [3:0] {
        AluAdd   = 4'b0000,
        AluSlt   = 4'b0010,
        AluXor   = 4'b0100,
        AluOr    = 4'b0110,
        AluAnd   = 4'b0111,
        AluSub   = 4'b1000,
        AluPassB = 4'b1111    // Operand B straight through
    } aluOpT;

    typedef enum logic [1:0] {
        WbAlu = 2'b00,
        WbMem = 2'b01,
        WbImm = 2'b10
    } wbSelT;

endpackage

`default_nettype wire

// ==== src/instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter int ImemDepth = 64
) (
    input  logic                           CLK,
    input  logic                           loadEn,
    input  logic [$clog2(ImemDepth)-1:0]   loadAddr,
    input  logic [cpuPkg::Xlen-1:0]        loadData,
    input  logic [cpuPkg::Xlen-1:0]        pc,
    output logic [cpuPkg::Xlen-1:0]        instr
);
    import cpuPkg::*;

    localparam int AddrW = $clog2(ImemDepth);

    logic [Xlen-1:0] mem [ImemDepth];

    // Unloaded words stay zero and decode as illegal
    initial begin
        for (int i = 0; i < ImemDepth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign instr = mem[pc[AddrW+1:2]];    // Byte PC to word index, wraps at depth

    // PC is unknown until the first reset edge
    assert property (@(posedge CLK) (!loadEn && !$isunknown(pc)) |-> pc[1:0] == 2'b00)
        else $error("instrMem: misaligned fetch at pc %h", pc);

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic [cpuPkg::RegAddrW-1:0]   rs1,
    input  logic [cpuPkg::RegAddrW-1:0]   rs2,
    input  logic [cpuPkg::RegAddrW-1:0]   rd,
    input  logic                          we,
    input  logic [cpuPkg::Xlen-1:0]       wdata,
    output logic [cpuPkg::Xlen-1:0]       rs1Data,
    output logic [cpuPkg::Xlen-1:0]       rs2Data
);
    import cpuPkg::*;

    localparam int RegCount = 2 ** RegAddrW;

    logic [Xlen-1:0] regs [RegCount];
    logic            writeOk;

    assign writeOk = we && (rd != '0);    // x0 writes dropped here

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeOk) begin
            regs[rd] <= wdata;
        end
    end

    // Plain reads, x0 stays zero since it is never written
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    assert property (@(posedge CLK) disable iff (rst) regs[0] == '0)
        else $error("regFile: x0 holds %h", regs[0]);

endmodule

`default_nettype wire

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  logic [cpuPkg::Xlen-1:0]       instr,
    output logic [cpuPkg::RegAddrW-1:0]   rs1,
    output logic [cpuPkg::RegAddrW-1:0]   rs2,
    output logic [cpuPkg::RegAddrW-1:0]   rd,
    output logic [cpuPkg::Xlen-1:0]       imm,
    output cpuPkg::aluOpT                 aluOp,
    output logic                          aluSrcImm,
    output logic                          isBranch,
    output logic                          branchNe,
    output logic                          memRead,
    output logic                          memWrite,
    output logic                          regWrite,
    output cpuPkg::wbSelT                 wbSel,
    output logic                          illegal
);
    import cpuPkg::*;

    opcodeT             opcode;
    logic [Funct3W-1:0] funct3;
    logic [3:0]         aluCtl;
    logic               funct7Clear;
    logic [Xlen-1:0]    immI;
    logic [Xlen-1:0]    immS;
    logic [Xlen-1:0]    immB;
    logic [Xlen-1:0]    immU;
    logic               bad;

    assign opcode = opcodeT'(instr[OpcodeW-1:0]);
    assign funct3 = instr[Funct3Lsb +: Funct3W];
    assign rd     = instr[RdLsb +: RegAddrW];
    assign rs1    = instr[Rs1Lsb +: RegAddrW];
    assign rs2    = instr[Rs2Lsb +: RegAddrW];

    assign aluCtl      = {instr[AltBit], funct3};    // Same pairing as the ALU control input
    assign funct7Clear = ({instr[Xlen-1], instr[AltBit-1:Funct7Lsb]} == '0);

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        imm       = '0;
        aluOp     = AluAdd;
        aluSrcImm = 1'b0;
        isBranch  = 1'b0;
        branchNe  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        wbSel     = WbAlu;
        bad       = 1'b0;

        case (opcode)
            OpReg: begin
                regWrite = 1'b1;
                case (aluCtl)
                    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt: begin
                        aluOp = aluOpT'(aluCtl);
                        bad   = !funct7Clear;
                    end
                    default: bad = 1'b1;
                endcase
            end
            OpImm: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                // Bit 30 is immediate here, so only funct3 counts
                case ({1'b0, funct3})
                    AluAdd, AluAnd, AluOr, AluXor, AluSlt: aluOp = aluOpT'({1'b0, funct3});
                    default: bad = 1'b1;    // Shifts and sltiu
                endcase
            end
            OpLoad: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                wbSel     = WbMem;
                bad       = (funct3 != 3'b010);    // lw only
            end
            OpStore: begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                bad       = (funct3 != 3'b010);
            end
            OpBranch: begin
                imm      = immB;
                aluOp    = AluSub;    // Zero flag gives equality
                isBranch = 1'b1;
                branchNe = funct3[0];
                bad      = (funct3[2:1] != 2'b00);
            end
            OpLui: begin
                imm       = immU;
                aluOp     = AluPassB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                wbSel     = WbImm;
            end
            default: bad = 1'b1;
        endcase

        // Illegal retires as a no-op
        if (bad) begin
            regWrite = 1'b0;
            memRead  = 1'b0;
            memWrite = 1'b0;
            isBranch = 1'b0;
        end
    end

    assign illegal = bad;

    assert final (!(memRead && memWrite))
        else $error("decodeUnit: load and store decoded together for %h", instr);

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  logic [cpuPkg::Xlen-1:0]   pc,
    input  logic [cpuPkg::Xlen-1:0]   rs1Data,
    input  logic [cpuPkg::Xlen-1:0]   rs2Data,
    input  logic [cpuPkg::Xlen-1:0]   imm,
    input  cpuPkg::aluOpT             aluOp,
    input  logic                      aluSrcImm,
    input  logic                      isBranch,
    input  logic                      branchNe,
    output logic [cpuPkg::Xlen-1:0]   aluResult,
    output logic [cpuPkg::Xlen-1:0]   nextPc
);
    import cpuPkg::*;

    logic [Xlen-1:0] opA;
    logic [Xlen-1:0] opB;
    logic            lessThan;
    logic            zero;
    logic            taken;
    logic [Xlen-1:0] pcPlus4;
    logic [Xlen-1:0] pcTarget;

    assign opA = rs1Data;
    assign opB = aluSrcImm ? imm : rs2Data;    // Immediate or rs2

    assign lessThan = ($signed(opA) < $signed(opB));

    always_comb begin
        case (aluOp)
            AluAdd:   aluResult = opA + opB;
            AluSub:   aluResult = opA - opB;
            AluAnd:   aluResult = opA & opB;
            AluOr:    aluResult = opA | opB;
            AluXor:   aluResult = opA ^ opB;
            AluSlt:   aluResult = {{(Xlen-1){1'b0}}, lessThan};
            AluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq wants zero set, bne wants it clear
    assign taken = isBranch && (zero != branchNe);

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign nextPc   = taken ? pcTarget : pcPlus4;

endmodule

`default_nettype wire

// ==== src/resultUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultUnit #(
    parameter int DmemDepth = 64
) (
    input  logic                      CLK,
    input  logic                      step,
    input  logic [cpuPkg::Xlen-1:0]   aluResult,
    input  logic [cpuPkg::Xlen-1:0]   storeData,
    input  logic [cpuPkg::Xlen-1:0]   imm,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  cpuPkg::wbSelT             wbSel,
    output logic [cpuPkg::Xlen-1:0]   wbData
);
    import cpuPkg::*;

    localparam int AddrW = $clog2(DmemDepth);

    logic [Xlen-1:0]  mem [DmemDepth];
    logic [AddrW-1:0] wordIdx;
    logic [Xlen-1:0]  loadWord;

    // Only cleared at time zero
    initial begin
        for (int i = 0; i < DmemDepth; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIdx = aluResult[AddrW+1:2];    // Wraps at depth

    always_ff @(posedge CLK) begin
        if (memWrite && step) begin
            mem[wordIdx] <= storeData;
        end
    end

    assign loadWord = memRead ? mem[wordIdx] : '0;

    always_comb begin
        case (wbSel)
            WbAlu:   wbData = aluResult;
            WbMem:   wbData = loadWord;
            WbImm:   wbData = imm;
            default: wbData = '0;
        endcase
    end

    // Address comes from the ALU, access flags from decode
    assert property (@(posedge CLK) (step && (memRead || memWrite)) |-> aluResult[1:0] == 2'b00)
        else $error("resultUnit: misaligned access at %h", aluResult);

endmodule

`default_nettype wire

// ==== src/singleCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleCpu #(
    parameter int ImemDepth = 64,
    parameter int DmemDepth = 64
) (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          loadEn,
    input  logic [$clog2(ImemDepth)-1:0]  loadAddr,
    input  logic [cpuPkg::Xlen-1:0]       loadData,
    output logic                          retireValid,
    output logic [cpuPkg::Xlen-1:0]       retirePc,
    output logic [cpuPkg::Xlen-1:0]       retireInstr,
    output logic                          retireRegWe,
    output logic [cpuPkg::RegAddrW-1:0]   retireRd,
    output logic [cpuPkg::Xlen-1:0]       retireData,
    output logic                          retireIllegal
);
    import cpuPkg::*;

    logic [Xlen-1:0]     pc;
    logic [Xlen-1:0]     nextPc;
    logic [Xlen-1:0]     instr;
    logic                step;
    logic                imemLoadEn;
    logic [RegAddrW-1:0] rs1;
    logic [RegAddrW-1:0] rs2;
    logic [RegAddrW-1:0] rd;
    logic [Xlen-1:0]     imm;
    aluOpT               aluOp;
    logic                aluSrcImm;
    logic                isBranch;
    logic                branchNe;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    wbSelT               wbSel;
    logic                illegal;
    logic [Xlen-1:0]     rs1Data;
    logic [Xlen-1:0]     rs2Data;
    logic [Xlen-1:0]     aluResult;
    logic [Xlen-1:0]     wbData;
    logic                rfWe;
    logic                rdWritten;

    assign step       = run && !rst;    // One instruction per edge
    assign imemLoadEn = loadEn && !run;    // Loads only while halted
    assign rfWe       = regWrite && step;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (step) begin
            pc <= nextPc;
        end
    end

    instrMem #(.ImemDepth(ImemDepth)) instrMem_i (
        .CLK(CLK), .loadEn(imemLoadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instr(instr)
    );

    regFile regFile_i (
        .CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rfWe), .wdata(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    decodeUnit decodeUnit_i (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch), .branchNe(branchNe),
        .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite), .wbSel(wbSel),
        .illegal(illegal)
    );

    executeUnit executeUnit_i (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch), .branchNe(branchNe),
        .aluResult(aluResult), .nextPc(nextPc)
    );

    resultUnit #(.DmemDepth(DmemDepth)) resultUnit_i (
        .CLK(CLK), .step(step), .aluResult(aluResult), .storeData(rs2Data), .imm(imm),
        .memRead(memRead), .memWrite(memWrite), .wbSel(wbSel), .wbData(wbData)
    );

    // Retire record of the instruction at the current PC
    assign rdWritten     = regWrite && (rd != '0);
    assign retireValid   = step;
    assign retirePc      = pc;
    assign retireInstr   = instr;
    assign retireRegWe   = rdWritten;
    assign retireRd      = rd;
    assign retireData    = rdWritten ? wbData : '0;
    assign retireIllegal = illegal;

endmodule

`default_nettype wire

// ==== verif/singleCpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module singleCpuTb;

    localparam int ImemDepth   = 64;
    localparam int DmemDepth   = 64;
    localparam int LoadAddrW   = $clog2(ImemDepth);
    localparam int Period      = 100;
    localparam int ResetCycles = 5;
    localparam int DriveDelay  = 10;
    localparam int PauseAfter  = 10;    // Records retired before run drops
    localparam int PauseCycles = 3;

    logic                 CLK;
    logic                 rst;
    logic                 run;
    logic                 loadEn;
    logic [LoadAddrW-1:0] loadAddr;
    logic [31:0]          loadData;
    logic                 retireValid;
    logic [31:0]          retirePc;
    logic [31:0]          retireInstr;
    logic                 retireRegWe;
    logic [4:0]           retireRd;
    logic [31:0]          retireData;
    logic                 retireIllegal;

    // Program words and expected retire records from the trace
    logic [31:0] loadAddrQ [$];
    logic [31:0] loadDataQ [$];
    logic [31:0] expPcQ [$];
    logic [31:0] expInstrQ [$];
    logic [31:0] expWeQ [$];
    logic [31:0] expRdQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] expIllQ [$];

    int   errors;
    int   recIdx;
    logic traceReady;
    logic paused;

    singleCpu #(.ImemDepth(ImemDepth), .DmemDepth(DmemDepth)) singleCpu_i (
        .CLK(CLK), .rst(rst), .run(run),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .retireValid(retireValid), .retirePc(retirePc), .retireInstr(retireInstr),
        .retireRegWe(retireRegWe), .retireRd(retireRd), .retireData(retireData),
        .retireIllegal(retireIllegal)
    );

    always #(Period / 2) CLK = ~CLK;

    task automatic readTrace();
        int                fd;
        int                n;
        logic [7:0]        tag;
        logic [8*120-1:0]  restLine;
        logic [31:0]       f0, f1, f2, f3, f4, f5;
        logic              scanOn;
        fd = $fopen("verif/cpuTrace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file verif/cpuTrace.txt");
        end else begin
            scanOn = 1'b1;
            while (scanOn) begin
                n = $fscanf(fd, " %c", tag);
                if (n != 1) begin
                    scanOn = 1'b0;
                end else if (tag == "#") begin
                    n = $fgets(restLine, fd);    // Comment line
                end else if (tag == "L") begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    loadAddrQ.push_back(f0);
                    loadDataQ.push_back(f1);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    expPcQ.push_back(f0);
                    expInstrQ.push_back(f1);
                    expWeQ.push_back(f2);
                    expRdQ.push_back(f3);
                    expDataQ.push_back(f4);
                    expIllQ.push_back(f5);
                end else begin
                    errors++;
                    $display("The trace holds a line with unknown tag '%c'", tag);
                    n = $fgets(restLine, fd);
                end
            end
            $fclose(fd);
            if (expPcQ.size() == 0) begin
                errors++;
                $display("The trace holds no expected retire records");
            end
        end
    endtask

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("[FAIL] %0d ns: record %0d %s expected %h, got %h",
                     $time, recIdx, name, expVal, actVal);
        end
    endtask

    task automatic compareRecord();
        compareField("retirePc", expPcQ[recIdx], retirePc);
        compareField("retireInstr", expInstrQ[recIdx], retireInstr);
        compareField("retireRegWe", expWeQ[recIdx], {31'b0, retireRegWe});
        compareField("retireRd", expRdQ[recIdx], {27'b0, retireRd});
        compareField("retireData", expDataQ[recIdx], retireData);
        compareField("retireIllegal", expIllQ[recIdx], {31'b0, retireIllegal});
    endtask

    // No retire expected in this cycle, returns just after the next edge
    task automatic idleCycle(input string why);
        @(negedge CLK);
        if (retireValid) begin
            errors++;
            $display("[FAIL] %0d ns: retire record seen while %s", $time, why);
        end
        @(posedge CLK);
        #DriveDelay;
    endtask

    initial begin
        CLK        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        errors     = 0;
        recIdx     = 0;
        paused     = 1'b0;
        traceReady = 1'b0;
        readTrace();
        traceReady = 1'b1;

        repeat (ResetCycles) @(posedge CLK);
        #DriveDelay;
        rst = 1'b0;

        // Program load with the core halted
        for (int i = 0; i < loadAddrQ.size(); i++) begin
            loadEn   = 1'b1;
            loadAddr = loadAddrQ[i][LoadAddrW-1:0];
            loadData = loadDataQ[i];
            idleCycle("loading with run low");
        end
        loadEn = 1'b0;
        run    = 1'b1;

        // Records sampled mid-cycle, each one executes at the next edge
        while (recIdx < expPcQ.size()) begin
            @(negedge CLK);
            if (retireValid) begin
                compareRecord();
                recIdx++;
            end
            @(posedge CLK);
            #DriveDelay;
            if (recIdx == PauseAfter && !paused) begin
                paused = 1'b1;
                run    = 1'b0;
                repeat (PauseCycles) idleCycle("run is low mid-program");
                run = 1'b1;    // Next record must carry the held PC
            end
        end
        run = 1'b0;

        $display("Errors: %0d, records checked: %0d of %0d", errors, recIdx, expPcQ.size());
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Budget of one period per trace line plus slack for reset and the pause
    initial begin
        wait (traceReady);
        #((loadAddrQ.size() + expPcQ.size() + 20) * Period);
        $display("Timeout: %0d expected retire records were never seen",
                 expPcQ.size() - recIdx);
        $display("Errors: %0d, records checked: %0d of %0d", errors, recIdx, expPcQ.size());
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/cpuTrace.txt ====
# L <word index> <instruction word>
# E <pc> <instr> <regWe> <rd> <data> <illegal>
L 00 00500093
L 01 FFD00113
L 02 123451B7
L 03 56718193
L 04 00208233
L 05 402082B3
L 06 0021F333
L 07 0051E3B3
L 08 0021C433
L 09 001124B3
L 0A 0F01F593
L 0B F000E613
L 0C FFF1C693
L 0D FFE12713
L 0E FFF0A793
L 0F FE82AE23
L 10 00402883
L 11 00708013
L 12 00208463
L 13 00209463
L 15 001A0A13
L 16 FE4A1EE3
L 17 01420463
L 1A 00008933
# Words 14 and 18 are skipped by branches, word 19 stays zero and is illegal
E 00000000 00500093 1 01 00000005 0
E 00000004 FFD00113 1 02 FFFFFFFD 0
E 00000008 123451B7 1 03 12345000 0
E 0000000C 56718193 1 03 12345567 0
E 00000010 00208233 1 04 00000002 0
E 00000014 402082B3 1 05 00000008 0
E 00000018 0021F333 1 06 12345565 0
E 0000001C 0051E3B3 1 07 1234556F 0
E 00000020 0021C433 1 08 EDCBAA9A 0
E 00000024 001124B3 1 09 00000001 0
E 00000028 0F01F593 1 0B 00000060 0
E 0000002C F000E613 1 0C FFFFFF05 0
E 00000030 FFF1C693 1 0D EDCBAA98 0
E 00000034 FFE12713 1 0E 00000001 0
E 00000038 FFF0A793 1 0F 00000000 0
E 0000003C FE82AE23 0 1C 00000000 0
E 00000040 00402883 1 11 EDCBAA9A 0
E 00000044 00708013 0 00 00000000 0
E 00000048 00208463 0 08 00000000 0
E 0000004C 00209463 0 08 00000000 0
E 00000054 001A0A13 1 14 00000001 0
E 00000058 FE4A1EE3 0 1D 00000000 0
E 00000054 001A0A13 1 14 00000002 0
E 00000058 FE4A1EE3 0 1D 00000000 0
E 0000005C 01420463 0 08 00000000 0
E 00000064 00000000 0 00 00000000 1
E 00000068 00008933 1 12 00000005 0

// ==== all.f ====
src/cpuPkg.sv
src/instrMem.sv
src/regFile.sv
src/decodeUnit.sv
src/executeUnit.sv
src/resultUnit.sv
src/singleCpu.sv
verif/singleCpuTb.sv
